//--- recorder_pkg.sv
// Shared sizes, port map and encodings for the message recorder
package recorder_pkg;

	//////////////////////////////////////////////////
	// Data path and memory sizes
	//////////////////////////////////////////////////

	// One audio sample per memory word
	localparam int DATA_W = 16;
	// Processor port bus
	localparam int BYTE_W = 8;

	localparam int ADDR_W = 7;
	localparam int SLOT_W = 3;
	localparam int MODE_W = 3;
	localparam int VOL_W = 4;

	// Five equal slots, kept tiny for simulation
	localparam int SLOT_COUNT = 5;
	localparam logic [ADDR_W-1:0] SLOT_WORDS = 7'd16;
	// SLOT_COUNT * SLOT_WORDS - 1
	localparam logic [ADDR_W-1:0] MEM_LAST = 7'd79;

	// Volume range, level 0 never used
	localparam logic [VOL_W-1:0] VOL_MIN = 4'd1;
	localparam logic [VOL_W-1:0] VOL_MAX = 4'd15;
	localparam logic [VOL_W-1:0] VOL_RESET = 4'd1;

	//////////////////////////////////////////////////
	// Processor port numbers
	//////////////////////////////////////////////////

	// Output ports, written by the processor
	localparam logic [BYTE_W-1:0] PORT_VOLUME = 8'h04;
	localparam logic [BYTE_W-1:0] PORT_RECORD = 8'h05;
	localparam logic [BYTE_W-1:0] PORT_MODE = 8'h0B;
	localparam logic [BYTE_W-1:0] PORT_FILE = 8'h0C;

	// Input ports, read back by the processor
	localparam logic [BYTE_W-1:0] PORT_SELECT = 8'h08;
	localparam logic [BYTE_W-1:0] PORT_BACK = 8'h09;
	localparam logic [BYTE_W-1:0] PORT_PAUSE = 8'h0A;
	localparam logic [BYTE_W-1:0] PORT_DEL_DONE = 8'h0F;

	//////////////////////////////////////////////////
	// Opcodes and sequencer states
	//////////////////////////////////////////////////

	// Value written to PORT_MODE
	typedef enum logic [MODE_W-1:0] {
		MODE_MAIN   = 3'd0,
		MODE_PLAY   = 3'd1,
		MODE_RECORD = 3'd2,
		MODE_DELONE = 3'd3,
		MODE_DELALL = 3'd4,
		MODE_VOLUME = 3'd5
	} mode_e;

	// Value written to PORT_VOLUME
	typedef enum logic [1:0] {
		VOL_UP   = 2'd1,
		VOL_DOWN = 2'd2
	} vol_cmd_e;

	typedef enum logic [3:0] {
		ST_MAIN,
		ST_PLAY_WAIT,
		ST_READ_REQ,
		ST_READ_WAIT,
		ST_READ_ACK,
		ST_RECORD_WAIT,
		ST_WRITE,
		ST_WRITE_STEP,
		ST_DEL_WRITE,
		ST_DEL_STEP
	} state_e;

endpackage

//--- cmd_if.sv
`timescale 1ns/1ps

// Decoded processor commands, all driven by the port decoder
interface cmd_if;

	// Levels, held until the processor rewrites them
	recorder_pkg::mode_e mode;
	logic [recorder_pkg::SLOT_W-1:0] slot;
	logic slot_valid;
	logic record_enable;

	// Single-cycle pulses
	logic mode_write;
	logic vol_step_up;
	logic vol_step_down;

	modport decoder (
		output mode,
		output mode_write,
		output slot,
		output slot_valid,
		output record_enable,
		output vol_step_up,
		output vol_step_down
	);

	// Sequencer only needs the control levels
	modport sequencer (input mode, input mode_write, input slot_valid, input record_enable);

	modport volume (input vol_step_up, input vol_step_down);

endinterface

//--- addr_if.sv
`timescale 1ns/1ps

// Sequencer to address counter
interface addr_if;

	// Requests from the sequencer, at most one per cycle
	logic load_slot;
	logic load_all;
	logic step;

	// Counter state
	logic [recorder_pkg::ADDR_W-1:0] address;
	logic at_end;

	modport sequencer (
		output load_slot,
		output load_all,
		output step,
		input  at_end
	);

	modport counter (
		input  load_slot,
		input  load_all,
		input  step,
		output address,
		output at_end
	);

endinterface

//--- port_decoder.sv
`timescale 1ns/1ps

// Processor port bus to command registers, plus input port mux
module port_decoder (
	input  logic clk2,
	input  logic pb_reset,
	input  logic [recorder_pkg::BYTE_W-1:0] port_id,
	input  logic [recorder_pkg::BYTE_W-1:0] out_port,
	input  logic write_strobe,
	input  logic read_strobe,
	input  logic select,
	input  logic back,
	input  logic pause_play,
	input  logic del_done,
	output logic [recorder_pkg::BYTE_W-1:0] in_port,
	cmd_if.decoder cmd
);

	logic bus_write;
	logic write_mode;
	logic write_file;
	logic write_volume;
	logic write_record;
	logic mode_legal;
	logic file_legal;
	logic in_volume;
	recorder_pkg::mode_e mode_decoded;

	// Both strobes at once is not a bus cycle the processor makes
	assign bus_write = write_strobe & ~read_strobe;

	// Output port select
	assign write_mode = bus_write && (port_id == recorder_pkg::PORT_MODE);
	assign write_file = bus_write && (port_id == recorder_pkg::PORT_FILE);
	assign write_volume = bus_write && (port_id == recorder_pkg::PORT_VOLUME);
	assign write_record = bus_write && (port_id == recorder_pkg::PORT_RECORD);

	// Unknown mode codes fall back to the main menu
	assign mode_legal = (out_port <=
		{{(recorder_pkg::BYTE_W-recorder_pkg::MODE_W){1'b0}}, recorder_pkg::MODE_VOLUME});
	assign mode_decoded = mode_legal ?
		recorder_pkg::mode_e'(out_port[recorder_pkg::MODE_W-1:0]) : recorder_pkg::MODE_MAIN;

	// Slots 0 to 4 in every mode
	assign file_legal = (int'(out_port) < recorder_pkg::SLOT_COUNT);

	assign in_volume = (cmd.mode == recorder_pkg::MODE_VOLUME);

	//////////////////////////////////////////////////
	// Command registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			cmd.mode <= recorder_pkg::MODE_MAIN;
			cmd.mode_write <= 1'b0;
			cmd.slot <= '0;
			cmd.slot_valid <= 1'b0;
			cmd.record_enable <= 1'b0;
			cmd.vol_step_up <= 1'b0;
			cmd.vol_step_down <= 1'b0;
		end else begin
			cmd.mode_write <= write_mode;
			// Volume steps only count in volume mode
			cmd.vol_step_up <= write_volume && in_volume &&
				(out_port == {{(recorder_pkg::BYTE_W-2){1'b0}}, recorder_pkg::VOL_UP});
			cmd.vol_step_down <= write_volume && in_volume &&
				(out_port == {{(recorder_pkg::BYTE_W-2){1'b0}}, recorder_pkg::VOL_DOWN});

			// New mode needs a new slot, and recording is disarmed
			if (write_mode) begin
				cmd.mode <= mode_decoded;
				cmd.slot_valid <= 1'b0;
				cmd.record_enable <= 1'b0;
			end
			if (write_file) begin
				cmd.slot <= out_port[recorder_pkg::SLOT_W-1:0];
				cmd.slot_valid <= file_legal;
			end
			if (write_record && (cmd.mode == recorder_pkg::MODE_RECORD)) begin
				cmd.record_enable <= (out_port == 8'h01);
			end
		end
	end

	//////////////////////////////////////////////////
	// Input port mux, one cycle behind port_id
	//////////////////////////////////////////////////

	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			in_port <= '0;
		end else begin
			case (port_id)
				recorder_pkg::PORT_SELECT: in_port <= {{(recorder_pkg::BYTE_W-1){1'b0}}, select};
				recorder_pkg::PORT_BACK: in_port <= {{(recorder_pkg::BYTE_W-1){1'b0}}, back};
				recorder_pkg::PORT_PAUSE: in_port <= {{(recorder_pkg::BYTE_W-1){1'b0}}, pause_play};
				recorder_pkg::PORT_DEL_DONE: in_port <= {{(recorder_pkg::BYTE_W-1){1'b0}}, del_done};
				// Nothing else is readable
				default: in_port <= '0;
			endcase
		end
	end

endmodule

//--- recorder_fsm.sv
`timescale 1ns/1ps

// Play, record and delete sequencer
module recorder_fsm (
	input  logic clk2,
	input  logic pb_reset,
	cmd_if.sequencer cmd,
	addr_if.sequencer addr,
	input  logic [recorder_pkg::DATA_W-1:0] mem_rd_data,
	input  logic mem_data_present,
	input  logic [recorder_pkg::DATA_W-1:0] audio_in,
	output logic [recorder_pkg::DATA_W-1:0] mem_wr_data,
	output logic mem_write_enable,
	output logic mem_read_request,
	output logic mem_read_ack,
	output logic [recorder_pkg::DATA_W-1:0] sample_out,
	output logic sample_strobe,
	output logic playback,
	output logic del_done
);

	recorder_pkg::state_e state;
	recorder_pkg::state_e state_next;
	logic op_armed;
	logic start_op;
	logic start_delete;

	// Memory strobes straight from the state
	assign mem_read_request = (state == recorder_pkg::ST_READ_REQ);
	assign mem_read_ack = (state == recorder_pkg::ST_READ_ACK);
	assign sample_strobe = (state == recorder_pkg::ST_READ_ACK);
	assign mem_write_enable = (state == recorder_pkg::ST_WRITE) ||
		(state == recorder_pkg::ST_DEL_WRITE);
	// Audio in record, zero for deletes
	assign mem_wr_data = (state == recorder_pkg::ST_WRITE) ? audio_in : '0;

	//////////////////////////////////////////////////
	// Next state and address control
	//////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		start_op = 1'b0;
		start_delete = 1'b0;
		addr.load_slot = 1'b0;
		addr.load_all = 1'b0;
		addr.step = 1'b0;
		case (state)
			recorder_pkg::ST_MAIN: begin
				// One operation per mode write
				if (op_armed) begin
					case (cmd.mode)
						recorder_pkg::MODE_PLAY: begin
							if (cmd.slot_valid) begin
								addr.load_slot = 1'b1;
								start_op = 1'b1;
								state_next = recorder_pkg::ST_PLAY_WAIT;
							end
						end
						recorder_pkg::MODE_RECORD: begin
							if (cmd.slot_valid) begin
								addr.load_slot = 1'b1;
								start_op = 1'b1;
								state_next = recorder_pkg::ST_RECORD_WAIT;
							end
						end
						recorder_pkg::MODE_DELONE: begin
							if (cmd.slot_valid) begin
								addr.load_slot = 1'b1;
								start_op = 1'b1;
								start_delete = 1'b1;
								state_next = recorder_pkg::ST_DEL_WRITE;
							end
						end
						// Whole memory, no slot needed
						recorder_pkg::MODE_DELALL: begin
							addr.load_all = 1'b1;
							start_op = 1'b1;
							start_delete = 1'b1;
							state_next = recorder_pkg::ST_DEL_WRITE;
						end
						default: ;
					endcase
				end
			end
			// Play loop
			recorder_pkg::ST_PLAY_WAIT: begin
				if (cmd.mode_write)
					state_next = recorder_pkg::ST_MAIN;
				else
					state_next = recorder_pkg::ST_READ_REQ;
			end
			recorder_pkg::ST_READ_REQ: state_next = recorder_pkg::ST_READ_WAIT;
			recorder_pkg::ST_READ_WAIT: begin
				// Latency varies, just wait
				if (mem_data_present)
					state_next = recorder_pkg::ST_READ_ACK;
			end
			recorder_pkg::ST_READ_ACK: begin
				addr.step = ~addr.at_end;
				state_next = addr.at_end ? recorder_pkg::ST_MAIN : recorder_pkg::ST_PLAY_WAIT;
			end
			// Record loop, two cycles a word while armed
			recorder_pkg::ST_RECORD_WAIT: begin
				if (cmd.mode_write)
					state_next = recorder_pkg::ST_MAIN;
				else if (cmd.record_enable)
					state_next = recorder_pkg::ST_WRITE;
			end
			recorder_pkg::ST_WRITE: state_next = recorder_pkg::ST_WRITE_STEP;
			recorder_pkg::ST_WRITE_STEP: begin
				addr.step = ~addr.at_end;
				if (addr.at_end)
					state_next = recorder_pkg::ST_MAIN;
				else if (cmd.record_enable)
					state_next = recorder_pkg::ST_WRITE;
				else
					state_next = recorder_pkg::ST_RECORD_WAIT;
			end
			// Delete loop, not abortable
			recorder_pkg::ST_DEL_WRITE: state_next = recorder_pkg::ST_DEL_STEP;
			recorder_pkg::ST_DEL_STEP: begin
				addr.step = ~addr.at_end;
				state_next = addr.at_end ? recorder_pkg::ST_MAIN : recorder_pkg::ST_DEL_WRITE;
			end
			default: state_next = recorder_pkg::ST_MAIN;
		endcase
	end

	//////////////////////////////////////////////////
	// State and status flags
	//////////////////////////////////////////////////

	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			state <= recorder_pkg::ST_MAIN;
			op_armed <= 1'b0;
			playback <= 1'b0;
			del_done <= 1'b0;
		end else begin
			state <= state_next;
			// Rearm on every mode write
			if (cmd.mode_write)
				op_armed <= 1'b1;
			else if (start_op)
				op_armed <= 1'b0;
			// Playback from first request until play ends
			if (state_next == recorder_pkg::ST_MAIN)
				playback <= 1'b0;
			else if (state_next == recorder_pkg::ST_READ_REQ)
				playback <= 1'b1;
			if (start_delete)
				del_done <= 1'b0;
			else if ((state == recorder_pkg::ST_DEL_STEP) && addr.at_end)
				del_done <= 1'b1;
		end
	end

	// Sample latched with the read ack
	always_ff @(posedge clk2) begin
		if ((state == recorder_pkg::ST_READ_WAIT) && mem_data_present)
			sample_out <= mem_rd_data;
	end

endmodule

//--- address_counter.sv
`timescale 1ns/1ps

// Memory address and end-of-range register
module address_counter (
	input  logic clk2,
	input  logic pb_reset,
	addr_if.counter addr,
	input  logic [recorder_pkg::SLOT_W-1:0] slot
);

	logic [recorder_pkg::ADDR_W-1:0] slot_base;
	logic [recorder_pkg::ADDR_W-1:0] slot_last;
	logic [recorder_pkg::ADDR_W-1:0] end_addr;

	// Base is slot times slot size
	assign slot_base = slot * recorder_pkg::SLOT_WORDS;
	assign slot_last = slot_base + recorder_pkg::SLOT_WORDS - 7'd1;

	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			addr.address <= '0;
			end_addr <= '0;
		end else begin
			if (addr.load_slot) begin
				addr.address <= slot_base;
				end_addr <= slot_last;
			end else if (addr.load_all) begin
				// Full memory for delete all
				addr.address <= '0;
				end_addr <= recorder_pkg::MEM_LAST;
			end else if (addr.step) begin
				addr.address <= addr.address + 7'd1;
			end
		end
	end

	// Last word of the current range
	assign addr.at_end = (addr.address == end_addr);

endmodule

//--- volume_ctrl.sv
`timescale 1ns/1ps

// Volume level, one step per command, saturating
module volume_ctrl (
	input  logic clk2,
	input  logic pb_reset,
	cmd_if.volume cmd,
	output logic [recorder_pkg::VOL_W-1:0] volume
);

	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			volume <= recorder_pkg::VOL_RESET;
		end else begin
			// Hold at either bound
			if (cmd.vol_step_up && (volume < recorder_pkg::VOL_MAX))
				volume <= volume + 4'd1;
			else if (cmd.vol_step_down && (volume > recorder_pkg::VOL_MIN))
				volume <= volume - 4'd1;
		end
	end

endmodule

//--- recorder_top.sv
`timescale 1ns/1ps

// Message recorder controller
module recorder_top (
	input  logic clk2,
	input  logic pb_reset,
	// Processor port bus
	input  logic [recorder_pkg::BYTE_W-1:0] port_id,
	input  logic [recorder_pkg::BYTE_W-1:0] out_port,
	input  logic write_strobe,
	input  logic read_strobe,
	output logic [recorder_pkg::BYTE_W-1:0] in_port,
	// Buttons
	input  logic select,
	input  logic back,
	input  logic pause_play,
	// Sample memory
	output logic [recorder_pkg::ADDR_W-1:0] mem_address,
	output logic [recorder_pkg::DATA_W-1:0] mem_wr_data,
	output logic mem_write_enable,
	output logic mem_read_request,
	output logic mem_read_ack,
	input  logic [recorder_pkg::DATA_W-1:0] mem_rd_data,
	input  logic mem_data_present,
	// Audio
	input  logic [recorder_pkg::DATA_W-1:0] audio_in,
	output logic [recorder_pkg::DATA_W-1:0] sample_out,
	output logic sample_strobe,
	output logic playback,
	output logic [recorder_pkg::VOL_W-1:0] volume
);

	logic del_done;

	cmd_if cmd_bus ();
	addr_if addr_bus ();

	assign mem_address = addr_bus.address;

	port_decoder u_decoder (
		.clk2(clk2),
		.pb_reset(pb_reset),
		.port_id(port_id),
		.out_port(out_port),
		.write_strobe(write_strobe),
		.read_strobe(read_strobe),
		.select(select),
		.back(back),
		.pause_play(pause_play),
		.del_done(del_done),
		.in_port(in_port),
		.cmd(cmd_bus.decoder)
	);

	recorder_fsm u_fsm (
		.clk2(clk2),
		.pb_reset(pb_reset),
		.cmd(cmd_bus.sequencer),
		.addr(addr_bus.sequencer),
		.mem_rd_data(mem_rd_data),
		.mem_data_present(mem_data_present),
		.audio_in(audio_in),
		.mem_wr_data(mem_wr_data),
		.mem_write_enable(mem_write_enable),
		.mem_read_request(mem_read_request),
		.mem_read_ack(mem_read_ack),
		.sample_out(sample_out),
		.sample_strobe(sample_strobe),
		.playback(playback),
		.del_done(del_done)
	);

	// Slot number taken directly from the command bus
	address_counter u_addr (
		.clk2(clk2),
		.pb_reset(pb_reset),
		.addr(addr_bus.counter),
		.slot(cmd_bus.slot)
	);

	volume_ctrl u_volume (
		.clk2(clk2),
		.pb_reset(pb_reset),
		.cmd(cmd_bus.volume),
		.volume(volume)
	);

endmodule

//--- tb_ram_model.sv
`timescale 1ns/1ps

// Sample memory with a variable read latency, counts writes
module tb_ram_model (
	input  logic clk2,
	input  logic pb_reset,
	input  logic [recorder_pkg::ADDR_W-1:0] mem_address,
	input  logic [recorder_pkg::DATA_W-1:0] mem_wr_data,
	input  logic mem_write_enable,
	input  logic mem_read_request,
	input  logic mem_read_ack,
	// Extra cycles of read latency, 0 to 3
	input  logic [1:0] latency,
	output logic [recorder_pkg::DATA_W-1:0] mem_rd_data,
	output logic mem_data_present,
	output int write_count
);

	logic [recorder_pkg::DATA_W-1:0] mem [0:recorder_pkg::MEM_LAST];
	logic [recorder_pkg::ADDR_W-1:0] read_addr;
	int wait_left;

	// Fill pattern from the full address
	initial begin
		for (int i = 0; i <= int'(recorder_pkg::MEM_LAST); i++)
			mem[i] = 16'(32'h5a00 ^ (i * 32'h0301));
	end

	always @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			mem_data_present <= 1'b0;
			mem_rd_data <= '0;
			read_addr <= '0;
			wait_left <= 0;
			write_count <= 0;
		end else begin
			// Writes land at the strobe edge
			if (mem_write_enable) begin
				mem[mem_address] <= mem_wr_data;
				write_count <= write_count + 1;
			end
			// Read answered 1 to 4 cycles after the request
			if (mem_read_request) begin
				read_addr <= mem_address;
				wait_left <= int'(latency) + 1;
			end else if (wait_left == 1) begin
				mem_data_present <= 1'b1;
				mem_rd_data <= mem[read_addr];
				wait_left <= 0;
			end else if (wait_left > 1) begin
				wait_left <= wait_left - 1;
			end
			// Data held until the ack
			if (mem_read_ack)
				mem_data_present <= 1'b0;
		end
	end

endmodule

//--- tb_recorder.sv
`timescale 1ns/1ps

// Testbench for the message recorder controller
module tb_recorder;

	localparam int PORT_TRIALS = 20;
	localparam int VOL_TRIALS = 40;
	localparam int IDLE_VOL_TRIALS = 8;
	localparam int SLOT_N = int'(recorder_pkg::SLOT_WORDS);
	localparam int MEM_WORDS = int'(recorder_pkg::MEM_LAST) + 1;
	// Two port trial runs plus record, play and both deletes
	localparam int TEST_WORDS = 2 * PORT_TRIALS + VOL_TRIALS + IDLE_VOL_TRIALS
		+ 3 * SLOT_N + MEM_WORDS;
	localparam int CYCLE_LIMIT = TEST_WORDS * 6 + 200;

	logic clk2 = 1'b0;
	logic pb_reset;
	logic [7:0] port_id;
	logic [7:0] out_port;
	logic write_strobe;
	logic read_strobe;
	logic [7:0] in_port;
	logic select;
	logic back;
	logic pause_play;
	logic [6:0] mem_address;
	logic [15:0] mem_wr_data;
	logic mem_write_enable;
	logic mem_read_request;
	logic mem_read_ack;
	logic [15:0] mem_rd_data;
	logic mem_data_present;
	logic [15:0] audio_in;
	logic [15:0] sample_out;
	logic sample_strobe;
	logic playback;
	logic [3:0] volume;
	logic [1:0] ram_latency;
	int ram_writes;

	// Reference state
	logic [15:0] expect_mem [0:MEM_WORDS-1];
	logic [15:0] record_log [$];
	logic [3:0] model_volume;
	logic model_del_done;
	int record_slot;
	int cycle_count = 0;
	logic [16:0] lfsr_state = 17'd99056;

	recorder_top uut (
		.clk2(clk2), .pb_reset(pb_reset),
		.port_id(port_id), .out_port(out_port),
		.write_strobe(write_strobe), .read_strobe(read_strobe), .in_port(in_port),
		.select(select), .back(back), .pause_play(pause_play),
		.mem_address(mem_address), .mem_wr_data(mem_wr_data),
		.mem_write_enable(mem_write_enable), .mem_read_request(mem_read_request),
		.mem_read_ack(mem_read_ack), .mem_rd_data(mem_rd_data),
		.mem_data_present(mem_data_present),
		.audio_in(audio_in), .sample_out(sample_out), .sample_strobe(sample_strobe),
		.playback(playback), .volume(volume)
	);

	tb_ram_model ram (
		.clk2(clk2), .pb_reset(pb_reset),
		.mem_address(mem_address), .mem_wr_data(mem_wr_data),
		.mem_write_enable(mem_write_enable), .mem_read_request(mem_read_request),
		.mem_read_ack(mem_read_ack), .latency(ram_latency),
		.mem_rd_data(mem_rd_data), .mem_data_present(mem_data_present),
		.write_count(ram_writes)
	);

	always #5 clk2 = ~clk2;

	//////////////////////////////////////////////////
	// Random source and helpers
	//////////////////////////////////////////////////

	// Fibonacci LFSR on x^17 + x^14 + 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[16] ^ lfsr_state[13];
		lfsr_state = {lfsr_state[15:0], fb};
		return fb;
	endfunction

	// One step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[30:0], lfsr_step()};
		return r;
	endfunction

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, expected);
			$display("Result: FAILED");
			$fatal(1, "simulation stopped");
		end
	endtask

	// Falling edge with a new memory latency for the next request
	task automatic next_cycle();
		@(negedge clk2);
		ram_latency = 2'(rand_bits(2));
	endtask

	// One processor write cycle
	task automatic bus_write(input logic [7:0] port, input logic [7:0] data);
		next_cycle();
		port_id = port;
		out_port = data;
		write_strobe = 1'b1;
		next_cycle();
		write_strobe = 1'b0;
	endtask

	// Rule for in_port
	function automatic logic [7:0] port_reference(input logic [7:0] port);
		case (port)
			recorder_pkg::PORT_SELECT: return {7'd0, select};
			recorder_pkg::PORT_BACK: return {7'd0, back};
			recorder_pkg::PORT_PAUSE: return {7'd0, pause_play};
			recorder_pkg::PORT_DEL_DONE: return {7'd0, model_del_done};
			default: return 8'd0;
		endcase
	endfunction

	task automatic check_memory();
		for (int i = 0; i < MEM_WORDS; i++)
			compare_value($sformatf("mem[%0d]", i), ram.mem[i], expect_mem[i]);
	endtask

	task automatic wait_writes(input int target);
		while (ram_writes < target)
			next_cycle();
	endtask

	// Poll the delete-done port
	task automatic wait_del_done();
		port_id = recorder_pkg::PORT_DEL_DONE;
		next_cycle();
		while (in_port !== 8'h01)
			next_cycle();
		model_del_done = 1'b1;
	endtask

	task automatic input_port_trials(input int n);
		logic [2:0] choice;
		logic [7:0] expected;
		for (int t = 0; t < n; t++) begin
			select = 1'(rand_bits(1));
			back = 1'(rand_bits(1));
			pause_play = 1'(rand_bits(1));
			choice = 3'(rand_bits(3));
			case (choice)
				3'd0: port_id = recorder_pkg::PORT_SELECT;
				3'd1: port_id = recorder_pkg::PORT_BACK;
				3'd2: port_id = recorder_pkg::PORT_PAUSE;
				3'd3: port_id = recorder_pkg::PORT_DEL_DONE;
				default: port_id = 8'(rand_bits(8));
			endcase
			expected = port_reference(port_id);
			next_cycle();
			compare_value("in_port", in_port, expected);
		end
	endtask

	// Cycle limit from the test lengths
	always @(posedge clk2) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT)
			fail_run("Timeout: the run took longer than its cycle limit");
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		int start;
		int base;
		int slot;
		int count;
		logic up;

		pb_reset = 1'b1;
		port_id = '0;
		out_port = '0;
		write_strobe = 1'b0;
		read_strobe = 1'b0;
		select = 1'b0;
		back = 1'b0;
		pause_play = 1'b0;
		audio_in = '0;
		ram_latency = 2'd0;
		repeat (4) @(negedge clk2);
		pb_reset = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++)
			expect_mem[i] = ram.mem[i];
		model_volume = recorder_pkg::VOL_RESET;
		model_del_done = 1'b0;

		// Reset values
		compare_value("mem_write_enable", mem_write_enable, 0);
		compare_value("mem_read_request", mem_read_request, 0);
		compare_value("mem_read_ack", mem_read_ack, 0);
		compare_value("sample_strobe", sample_strobe, 0);
		compare_value("playback", playback, 0);
		compare_value("volume", volume, 1);
		port_id = recorder_pkg::PORT_DEL_DONE;
		next_cycle();
		compare_value("in_port", in_port, 0);

		input_port_trials(PORT_TRIALS);

		// Volume steps against a saturating model
		bus_write(recorder_pkg::PORT_MODE, recorder_pkg::MODE_VOLUME);
		for (int t = 0; t < VOL_TRIALS; t++) begin
			up = 1'(rand_bits(1));
			bus_write(recorder_pkg::PORT_VOLUME,
				up ? recorder_pkg::VOL_UP : recorder_pkg::VOL_DOWN);
			if (up && model_volume < 4'd15)
				model_volume = model_volume + 4'd1;
			else if (!up && model_volume > 4'd1)
				model_volume = model_volume - 4'd1;
			next_cycle();
			compare_value("volume", volume, model_volume);
		end
		// Ignored outside volume mode
		bus_write(recorder_pkg::PORT_MODE, recorder_pkg::MODE_MAIN);
		for (int t = 0; t < IDLE_VOL_TRIALS; t++) begin
			up = 1'(rand_bits(1));
			bus_write(recorder_pkg::PORT_VOLUME,
				up ? recorder_pkg::VOL_UP : recorder_pkg::VOL_DOWN);
			next_cycle();
			compare_value("volume", volume, model_volume);
		end

		// Record one slot with new audio after each write
		record_slot = rand_bits(3) % recorder_pkg::SLOT_COUNT;
		base = record_slot * SLOT_N;
		start = ram_writes;
		audio_in = 16'(rand_bits(16));
		record_log.delete();
		bus_write(recorder_pkg::PORT_MODE, recorder_pkg::MODE_RECORD);
		bus_write(recorder_pkg::PORT_FILE, 8'(record_slot));
		bus_write(recorder_pkg::PORT_RECORD, 8'h01);
		while (record_log.size() < SLOT_N) begin
			next_cycle();
			if (ram_writes - start > record_log.size()) begin
				record_log.push_back(audio_in);
				audio_in = 16'(rand_bits(16));
			end
		end
		for (int i = 0; i < SLOT_N; i++)
			expect_mem[base + i] = record_log[i];
		next_cycle();
		check_memory();

		// Play it back in address order
		bus_write(recorder_pkg::PORT_MODE, recorder_pkg::MODE_PLAY);
		bus_write(recorder_pkg::PORT_FILE, 8'(record_slot));
		count = 0;
		while (count < SLOT_N) begin
			next_cycle();
			if (sample_strobe) begin
				compare_value("playback", playback, 1);
				// Ack goes out with the sample
				compare_value("mem_read_ack", mem_read_ack, 1);
				compare_value($sformatf("sample_out[%0d]", count), sample_out,
					expect_mem[base + count]);
				count++;
			end
		end
		next_cycle();
		compare_value("playback", playback, 0);
		// Recording stopped at the slot end
		compare_value("record write count", ram_writes - start, SLOT_N);

		// Delete one slot
		slot = rand_bits(3) % recorder_pkg::SLOT_COUNT;
		start = ram_writes;
		bus_write(recorder_pkg::PORT_MODE, recorder_pkg::MODE_DELONE);
		bus_write(recorder_pkg::PORT_FILE, 8'(slot));
		wait_writes(start + SLOT_N);
		wait_del_done();
		compare_value("delete one write count", ram_writes - start, SLOT_N);
		for (int i = 0; i < SLOT_N; i++)
			expect_mem[slot * SLOT_N + i] = '0;
		check_memory();

		// Delete all
		start = ram_writes;
		bus_write(recorder_pkg::PORT_MODE, recorder_pkg::MODE_DELALL);
		wait_writes(start + MEM_WORDS);
		wait_del_done();
		compare_value("delete all write count", ram_writes - start, MEM_WORDS);
		for (int i = 0; i < MEM_WORDS; i++)
			expect_mem[i] = '0;
		check_memory();

		// Done flag now set
		input_port_trials(PORT_TRIALS);

		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- sim.f
recorder_pkg.sv
cmd_if.sv
addr_if.sv
port_decoder.sv
recorder_fsm.sv
address_counter.sv
volume_ctrl.sv
recorder_top.sv
tb_ram_model.sv
tb_recorder.sv
